// File: src/sbox_pkg.sv
`default_nettype none

package sbox_pkg;

    localparam int BYTE_W     = 8;
    localparam int NIB_W      = 4;
    localparam int GF4_W      = 2;
    localparam int ID_W       = 4;
    localparam int NUM_STAGES = 5;

    localparam logic [BYTE_W-1:0] SBOX_AFF_C     = 8'h63;
    localparam logic [BYTE_W-1:0] SBOX_INV_AFF_C = 8'h05;

    // Bit matrices, one row mask per output bit, row 7 first
    localparam logic [BYTE_W-1:0][BYTE_W-1:0] ISO_ROWS = {
        8'hE7, 8'h71, 8'h63, 8'hE1, 8'h9B, 8'h01, 8'h61, 8'h4F
    };
    localparam logic [BYTE_W-1:0][BYTE_W-1:0] ISO_INV_ROWS = {
        8'h12, 8'hEB, 8'hED, 8'h42, 8'h7E, 8'hB2, 8'h22, 8'h04
    };
    localparam logic [BYTE_W-1:0][BYTE_W-1:0] AFF_ROWS = {
        8'hF8, 8'h7C, 8'h3E, 8'h1F, 8'h8F, 8'hC7, 8'hE3, 8'hF1
    };
    localparam logic [BYTE_W-1:0][BYTE_W-1:0] AFF_INV_ROWS = {
        8'h52, 8'h29, 8'h94, 8'h4A, 8'h25, 8'h92, 8'h49, 8'hA4
    };

    typedef struct packed {
        logic [GF4_W-1:0] hi;
        logic [GF4_W-1:0] lo;
    } gf4_pair_t;

    // GF(16) element in normal basis over GF(4)
    typedef union packed {
        logic [NIB_W-1:0] nib;
        gf4_pair_t        half;
    } gf16_t;

    function automatic logic [GF4_W-1:0] gf4_mul(input logic [GF4_W-1:0] a,
                                                 input logic [GF4_W-1:0] b);
        logic t;
        t = (a[1] ^ a[0]) & (b[1] ^ b[0]);
        return {(a[1] & b[1]) ^ t, (a[0] & b[0]) ^ t};
    endfunction

    // Squaring swaps the two normal basis coordinates
    function automatic logic [GF4_W-1:0] gf4_sq(input logic [GF4_W-1:0] x);
        return {x[0], x[1]};
    endfunction

    function automatic logic [GF4_W-1:0] gf4_scale_n(input logic [GF4_W-1:0] x);
        return {x[0], x[1] ^ x[0]};
    endfunction

    // x^-1 equals x^2 in GF(4)
    function automatic logic [GF4_W-1:0] gf4_inv(input logic [GF4_W-1:0] x);
        return gf4_sq(x);
    endfunction

    function automatic gf16_t gf16_mul(input gf16_t a, input gf16_t b);
        logic [GF4_W-1:0] t;
        gf16_t            r;
        t = gf4_scale_n(gf4_mul(a.half.hi ^ a.half.lo, b.half.hi ^ b.half.lo));
        r.half.hi = gf4_mul(a.half.hi, b.half.hi) ^ t;
        r.half.lo = gf4_mul(a.half.lo, b.half.lo) ^ t;
        return r;
    endfunction

    function automatic gf16_t gf16_sq_scale(input gf16_t x);
        gf16_t r;
        r.half.hi = gf4_sq(x.half.hi ^ x.half.lo);
        r.half.lo = gf4_sq(gf4_scale_n(x.half.lo));
        return r;
    endfunction

    function automatic logic [BYTE_W-1:0] gf2_mat_vec(
        input logic [BYTE_W-1:0]             x,
        input logic [BYTE_W-1:0][BYTE_W-1:0] rows
    );
        logic [BYTE_W-1:0] r;
        for (int i = 0; i < BYTE_W; i++)
        begin
            r[i] = ^(x & rows[i]);
        end
        return r;
    endfunction

    function automatic logic [BYTE_W-1:0] iso_map(input logic [BYTE_W-1:0] x);
        return gf2_mat_vec(x, ISO_ROWS);
    endfunction

    function automatic logic [BYTE_W-1:0] iso_map_inv(input logic [BYTE_W-1:0] x);
        return gf2_mat_vec(x, ISO_INV_ROWS);
    endfunction

    function automatic logic [BYTE_W-1:0] aff_mul(input logic [BYTE_W-1:0] x);
        return gf2_mat_vec(x, AFF_ROWS);
    endfunction

    function automatic logic [BYTE_W-1:0] aff_inv_mul(input logic [BYTE_W-1:0] x);
        return gf2_mat_vec(x, AFF_INV_ROWS);
    endfunction

endpackage

`default_nettype wire

// File: src/sbox_pipe_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module sbox_pipe_ctrl
    import sbox_pkg::*;
(
    input  wire                   clk_i,
    input  wire                   rst_n,
    input  wire                   valid_i,
    input  wire  [ID_W-1:0]       instr_id_i,
    input  wire                   decrypt_i,
    input  wire                   ready_i,
    output logic                  ready_o,
    output logic                  valid_o,
    output logic [ID_W-1:0]       instr_id_o,
    output logic [NUM_STAGES-1:0] stage_en_o,
    output logic                  decrypt_s6_o
);

    logic [NUM_STAGES-1:0]           stage_en;
    logic [NUM_STAGES-1:0]           stage_vld;
    logic [NUM_STAGES-1:0]           stage_dec;
    logic [NUM_STAGES-1:0][ID_W-1:0] stage_tag;

    // A stage moves when any stage from it to the end has room
    for (genvar g = 0; g < NUM_STAGES; g++)
    begin : g_ready
        assign stage_en[g] = ready_i || !(&stage_vld[NUM_STAGES-1:g]);
    end

    always_ff @(posedge clk_i or negedge rst_n)
    begin
        if (!rst_n)
        begin
            stage_vld <= '0;
        end
        else
        begin
            for (int i = 0; i < NUM_STAGES; i++)
            begin
                if (stage_en[i])
                begin
                    stage_vld[i] <= (i == 0) ? valid_i : stage_vld[i - 1];
                end
            end
        end
    end

    always_ff @(posedge clk_i)
    begin
        for (int i = 0; i < NUM_STAGES; i++)
        begin
            if (stage_en[i])
            begin
                stage_tag[i] <= (i == 0) ? instr_id_i : stage_tag[i - 1];
                stage_dec[i] <= (i == 0) ? decrypt_i : stage_dec[i - 1];
            end
        end
    end

    assign stage_en_o   = stage_en;
    assign ready_o      = stage_en[0];
    assign valid_o      = stage_vld[NUM_STAGES-1];
    assign instr_id_o   = stage_tag[NUM_STAGES-1];
    assign decrypt_s6_o = stage_dec[NUM_STAGES-1];

endmodule

`default_nettype wire

// File: src/sbox_input_map.sv
`timescale 1ns/1ns
`default_nettype none

module sbox_input_map
    import sbox_pkg::*;
(
    input  wire               clk_i,
    input  wire               decrypt_i,
    input  wire  [BYTE_W-1:0] share_a_i,
    input  wire  [BYTE_W-1:0] share_b_i,
    input  wire               stage_en_i,
    output gf16_t             a_hi_o,
    output gf16_t             a_lo_o,
    output gf16_t             b_hi_o,
    output gf16_t             b_lo_o
);

    logic [BYTE_W-1:0] a_pre, b_pre;
    logic [BYTE_W-1:0] a_tf, b_tf;

    // Inverse affine ahead of the inversion for decryption
    always_comb
    begin
        if (decrypt_i)
        begin
            // Constant goes on one share only
            a_pre = aff_inv_mul(share_a_i) ^ SBOX_INV_AFF_C;
            b_pre = aff_inv_mul(share_b_i);
        end
        else
        begin
            a_pre = share_a_i;
            b_pre = share_b_i;
        end
    end

    assign a_tf = iso_map(a_pre);
    assign b_tf = iso_map(b_pre);

    always_ff @(posedge clk_i)
    begin
        if (stage_en_i)
        begin
            a_hi_o.nib <= a_tf[BYTE_W-1:NIB_W];
            a_lo_o.nib <= a_tf[NIB_W-1:0];
            b_hi_o.nib <= b_tf[BYTE_W-1:NIB_W];
            b_lo_o.nib <= b_tf[NIB_W-1:0];
        end
    end

endmodule

`default_nettype wire

// File: src/gf256_inv_front.sv
`timescale 1ns/1ns
`default_nettype none

module gf256_inv_front
    import sbox_pkg::*;
(
    input  wire   clk_i,
    input  wire   stage_en_i,
    input  gf16_t a_hi_i,
    input  gf16_t a_lo_i,
    input  gf16_t b_hi_i,
    input  gf16_t b_lo_i,
    output gf16_t a_sum_o,
    output gf16_t b_sum_o
);

    gf16_t a_add, b_add;
    gf16_t a_sqs, b_sqs;
    gf16_t p_aa, p_ab, p_bb, p_ba;
    gf16_t a_sqs_q, b_sqs_q;
    gf16_t p_aa_q, p_ab_q, p_bb_q, p_ba_q;

    assign a_add.nib = a_hi_i.nib ^ a_lo_i.nib;
    assign b_add.nib = b_hi_i.nib ^ b_lo_i.nib;
    assign a_sqs     = gf16_sq_scale(a_add);
    assign b_sqs     = gf16_sq_scale(b_add);

    // DOM hi x lo, own domain and cross domain terms
    assign p_aa = gf16_mul(a_hi_i, a_lo_i);
    assign p_ab = gf16_mul(a_hi_i, b_lo_i);
    assign p_bb = gf16_mul(b_hi_i, b_lo_i);
    assign p_ba = gf16_mul(b_hi_i, a_lo_i);

    always_ff @(posedge clk_i)
    begin
        if (stage_en_i)
        begin
            p_aa_q  <= p_aa;
            p_ab_q  <= p_ab;
            p_bb_q  <= p_bb;
            p_ba_q  <= p_ba;
            a_sqs_q <= a_sqs;
            b_sqs_q <= b_sqs;
        end
    end

    assign a_sum_o.nib = p_aa_q.nib ^ p_ab_q.nib ^ a_sqs_q.nib;
    assign b_sum_o.nib = p_bb_q.nib ^ p_ba_q.nib ^ b_sqs_q.nib;

endmodule

`default_nettype wire

// File: src/gf16_inv_dom.sv
`timescale 1ns/1ns
`default_nettype none

module gf16_inv_dom
    import sbox_pkg::*;
(
    input  wire        clk_i,
    input  wire  [1:0] stage_en_i,
    input  gf16_t      a_sum_i,
    input  gf16_t      b_sum_i,
    output gf16_t      a_inv_o,
    output gf16_t      b_inv_o
);

    logic [GF4_W-1:0] a_sqn, b_sqn;
    logic [GF4_W-1:0] m_aa, m_ab, m_bb, m_ba;
    logic [GF4_W-1:0] m_aa_q, m_ab_q, m_bb_q, m_ba_q;
    logic [GF4_W-1:0] a_sqn_q, b_sqn_q;
    gf16_t            a_s4, b_s4;
    logic [GF4_W-1:0] a_ei, b_ei;
    gf16_t            r_aa, r_ab, r_bb, r_ba;
    gf16_t            r_aa_q, r_ab_q, r_bb_q, r_ba_q;

    // Stage 3
    assign a_sqn = gf4_scale_n(gf4_sq(a_sum_i.half.hi ^ a_sum_i.half.lo));
    assign b_sqn = gf4_scale_n(gf4_sq(b_sum_i.half.hi ^ b_sum_i.half.lo));
    assign m_aa  = gf4_mul(a_sum_i.half.hi, a_sum_i.half.lo);
    assign m_ab  = gf4_mul(a_sum_i.half.hi, b_sum_i.half.lo);
    assign m_bb  = gf4_mul(b_sum_i.half.hi, b_sum_i.half.lo);
    assign m_ba  = gf4_mul(b_sum_i.half.hi, a_sum_i.half.lo);

    always_ff @(posedge clk_i)
    begin
        if (stage_en_i[0])
        begin
            m_aa_q  <= m_aa;
            m_ab_q  <= m_ab;
            m_bb_q  <= m_bb;
            m_ba_q  <= m_ba;
            a_sqn_q <= a_sqn;
            b_sqn_q <= b_sqn;
            a_s4    <= a_sum_i;
            b_s4    <= b_sum_i;
        end
    end

    // Stage 4, inverse of the GF(4) determinant per share
    assign a_ei = gf4_inv(m_aa_q ^ m_ab_q ^ a_sqn_q);
    assign b_ei = gf4_inv(m_bb_q ^ m_ba_q ^ b_sqn_q);

    // New hi comes from old lo and vice versa
    assign r_aa = {gf4_mul(a_ei, a_s4.half.lo), gf4_mul(a_ei, a_s4.half.hi)};
    assign r_ab = {gf4_mul(a_ei, b_s4.half.lo), gf4_mul(a_ei, b_s4.half.hi)};
    assign r_bb = {gf4_mul(b_ei, b_s4.half.lo), gf4_mul(b_ei, b_s4.half.hi)};
    assign r_ba = {gf4_mul(b_ei, a_s4.half.lo), gf4_mul(b_ei, a_s4.half.hi)};

    always_ff @(posedge clk_i)
    begin
        if (stage_en_i[1])
        begin
            r_aa_q <= r_aa;
            r_ab_q <= r_ab;
            r_bb_q <= r_bb;
            r_ba_q <= r_ba;
        end
    end

    assign a_inv_o.nib = r_aa_q.nib ^ r_ab_q.nib;
    assign b_inv_o.nib = r_bb_q.nib ^ r_ba_q.nib;

endmodule

`default_nettype wire

// File: src/gf256_inv_back.sv
`timescale 1ns/1ns
`default_nettype none

module gf256_inv_back
    import sbox_pkg::*;
(
    input  wire               clk_i,
    input  wire  [3:0]        stage_en_i,
    input  gf16_t             a_hi_i,
    input  gf16_t             a_lo_i,
    input  gf16_t             b_hi_i,
    input  gf16_t             b_lo_i,
    input  gf16_t             a_inv_i,
    input  gf16_t             b_inv_i,
    input  wire               decrypt_s6_i,
    output logic [BYTE_W-1:0] share_a_o,
    output logic [BYTE_W-1:0] share_b_o
);

    // Stage 2 nibbles carried to stage 5, order a_hi a_lo b_hi b_lo
    gf16_t [3:0] nib_dly [3];

    gf16_t             s5_a_hi, s5_a_lo, s5_b_hi, s5_b_lo;
    logic [BYTE_W-1:0] m_aa, m_ab, m_bb, m_ba;
    logic [BYTE_W-1:0] m_aa_q, m_ab_q, m_bb_q, m_ba_q;
    logic [BYTE_W-1:0] a_byte, b_byte;
    logic [BYTE_W-1:0] a_std, b_std;

    always_ff @(posedge clk_i)
    begin
        if (stage_en_i[0])
        begin
            nib_dly[0] <= {a_hi_i, a_lo_i, b_hi_i, b_lo_i};
        end
        for (int i = 1; i < 3; i++)
        begin
            if (stage_en_i[i])
            begin
                nib_dly[i] <= nib_dly[i - 1];
            end
        end
    end

    assign s5_a_hi = nib_dly[2][3];
    assign s5_a_lo = nib_dly[2][2];
    assign s5_b_hi = nib_dly[2][1];
    assign s5_b_lo = nib_dly[2][0];

    // Output hi nibble uses the input lo nibble
    assign m_aa = {gf16_mul(a_inv_i, s5_a_lo), gf16_mul(a_inv_i, s5_a_hi)};
    assign m_ab = {gf16_mul(a_inv_i, s5_b_lo), gf16_mul(a_inv_i, s5_b_hi)};
    assign m_bb = {gf16_mul(b_inv_i, s5_b_lo), gf16_mul(b_inv_i, s5_b_hi)};
    assign m_ba = {gf16_mul(b_inv_i, s5_a_lo), gf16_mul(b_inv_i, s5_a_hi)};

    always_ff @(posedge clk_i)
    begin
        if (stage_en_i[3])
        begin
            m_aa_q <= m_aa;
            m_ab_q <= m_ab;
            m_bb_q <= m_bb;
            m_ba_q <= m_ba;
        end
    end

    assign a_byte = m_aa_q ^ m_ab_q;
    assign b_byte = m_bb_q ^ m_ba_q;
    assign a_std  = iso_map_inv(a_byte);
    assign b_std  = iso_map_inv(b_byte);

    always_comb
    begin
        if (decrypt_s6_i)
        begin
            share_a_o = a_std;
            share_b_o = b_std;
        end
        else
        begin
            share_a_o = aff_mul(a_std) ^ SBOX_AFF_C;
            share_b_o = aff_mul(b_std);
        end
    end

endmodule

`default_nettype wire

// File: src/masked_sbox_top.sv
`timescale 1ns/1ns
`default_nettype none

module masked_sbox_top
    import sbox_pkg::*;
(
    input  wire               clk_i,
    input  wire               rst_n,
    input  wire               valid_i,
    input  wire  [ID_W-1:0]   instr_id_i,
    input  wire               decrypt_i,
    input  wire  [BYTE_W-1:0] share_a_i,
    input  wire  [BYTE_W-1:0] share_b_i,
    input  wire               ready_i,
    output logic              ready_o,
    output logic              valid_o,
    output logic [ID_W-1:0]   instr_id_o,
    output logic [BYTE_W-1:0] share_a_o,
    output logic [BYTE_W-1:0] share_b_o
);

    // Bit 0 is stage 2, bit 4 is stage 6
    logic [NUM_STAGES-1:0] stage_en;
    logic                  decrypt_s6;

    gf16_t s2_a_hi, s2_a_lo, s2_b_hi, s2_b_lo;
    gf16_t s3_a_sum, s3_b_sum;
    gf16_t s5_a_inv, s5_b_inv;

    sbox_pipe_ctrl sbox_pipe_ctrl_inst (
        .clk_i        (clk_i),
        .rst_n        (rst_n),
        .valid_i      (valid_i),
        .instr_id_i   (instr_id_i),
        .decrypt_i    (decrypt_i),
        .ready_i      (ready_i),
        .ready_o      (ready_o),
        .valid_o      (valid_o),
        .instr_id_o   (instr_id_o),
        .stage_en_o   (stage_en),
        .decrypt_s6_o (decrypt_s6)
    );

    sbox_input_map sbox_input_map_inst (
        .clk_i      (clk_i),
        .decrypt_i  (decrypt_i),
        .share_a_i  (share_a_i),
        .share_b_i  (share_b_i),
        .stage_en_i (stage_en[0]),
        .a_hi_o     (s2_a_hi),
        .a_lo_o     (s2_a_lo),
        .b_hi_o     (s2_b_hi),
        .b_lo_o     (s2_b_lo)
    );

    gf256_inv_front gf256_inv_front_inst (
        .clk_i      (clk_i),
        .stage_en_i (stage_en[1]),
        .a_hi_i     (s2_a_hi),
        .a_lo_i     (s2_a_lo),
        .b_hi_i     (s2_b_hi),
        .b_lo_i     (s2_b_lo),
        .a_sum_o    (s3_a_sum),
        .b_sum_o    (s3_b_sum)
    );

    gf16_inv_dom gf16_inv_dom_inst (
        .clk_i      (clk_i),
        .stage_en_i (stage_en[3:2]),
        .a_sum_i    (s3_a_sum),
        .b_sum_i    (s3_b_sum),
        .a_inv_o    (s5_a_inv),
        .b_inv_o    (s5_b_inv)
    );

    gf256_inv_back gf256_inv_back_inst (
        .clk_i        (clk_i),
        .stage_en_i   (stage_en[4:1]),
        .a_hi_i       (s2_a_hi),
        .a_lo_i       (s2_a_lo),
        .b_hi_i       (s2_b_hi),
        .b_lo_i       (s2_b_lo),
        .a_inv_i      (s5_a_inv),
        .b_inv_i      (s5_b_inv),
        .decrypt_s6_i (decrypt_s6),
        .share_a_o    (share_a_o),
        .share_b_o    (share_b_o)
    );

endmodule

`default_nettype wire

// File: test/tb_sbox_model.svh
`ifndef TB_SBOX_MODEL_SVH
`define TB_SBOX_MODEL_SVH

localparam logic [31:0] LFSR_SEED = 32'h3d72_7f9a;

logic [31:0] lfsr_state = LFSR_SEED;

// Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
function automatic logic [31:0] lfsr_take(input int nbits);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < nbits; i++)
    begin
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        r = {r[30:0], fb};
    end
    return r;
endfunction

// GF(2^8) product modulo the AES polynomial
function automatic logic [7:0] gf256_mul_ref(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] p;
    logic [7:0] x;
    p = 8'h00;
    x = a;
    for (int i = 0; i < 8; i++)
    begin
        if (b[i])
        begin
            p = p ^ x;
        end
        x = x[7] ? ((x << 1) ^ 8'h1B) : (x << 1);
    end
    return p;
endfunction

// Brute force search, zero maps to zero
function automatic logic [7:0] gf256_inv_ref(input logic [7:0] a);
    logic [7:0] r;
    r = 8'h00;
    for (int c = 1; c < 256; c++)
    begin
        if (gf256_mul_ref(a, 8'(c)) == 8'h01)
        begin
            r = 8'(c);
        end
    end
    return r;
endfunction

function automatic logic [7:0] rotl8(input logic [7:0] x, input int n);
    return (x << n) | (x >> (8 - n));
endfunction

function automatic logic [7:0] sbox_ref(input logic [7:0] x);
    logic [7:0] b;
    b = gf256_inv_ref(x);
    return b ^ rotl8(b, 1) ^ rotl8(b, 2) ^ rotl8(b, 3) ^ rotl8(b, 4) ^ 8'h63;
endfunction

function automatic logic [7:0] inv_sbox_ref(input logic [7:0] x);
    return gf256_inv_ref(rotl8(x, 1) ^ rotl8(x, 3) ^ rotl8(x, 6) ^ 8'h05);
endfunction

`endif

// File: test/tb_masked_sbox.sv
`timescale 1ns/1ns
`default_nettype none

module tb_masked_sbox
    import sbox_pkg::*;
;

    localparam int CLK_PERIOD     = 4;
    localparam int NUM_ROWS       = 43;
    localparam int ACCEPT_TIMEOUT = 50;
    localparam int RESULT_TIMEOUT = 100;
    localparam int PIPE_LATENCY   = 5;

    // Known answers for rows 0 to 3
    // Rows 2 and 3 decrypt
    localparam logic [3:0][7:0] KAT_IN  = {8'hED, 8'h63, 8'h53, 8'h00};
    localparam logic [3:0][7:0] KAT_OUT = {8'h53, 8'h00, 8'hED, 8'h63};

    typedef struct packed {
        logic [7:0]      plain;
        logic [7:0]      mask;
        logic            dec;
        logic [ID_W-1:0] tag;
        logic [2:0]      stall;
        logic [7:0]      expected;
    } row_t;

    logic              clk_i;
    logic              rst_n;
    logic              valid_i;
    logic [ID_W-1:0]   instr_id_i;
    logic              decrypt_i;
    logic [BYTE_W-1:0] share_a_i;
    logic [BYTE_W-1:0] share_b_i;
    logic              ready_i;
    logic              ready_o;
    logic              valid_o;
    logic [ID_W-1:0]   instr_id_o;
    logic [BYTE_W-1:0] share_a_o;
    logic [BYTE_W-1:0] share_b_o;

    row_t                   stim_tab [NUM_ROWS];
    logic [ID_W+BYTE_W-1:0] exp_q [$];
    time                    acc_time_q [$];
    logic                   stalled_once;

    `include "tb_sbox_model.svh"

    masked_sbox_top masked_sbox_top_inst (
        .clk_i      (clk_i),
        .rst_n      (rst_n),
        .valid_i    (valid_i),
        .instr_id_i (instr_id_i),
        .decrypt_i  (decrypt_i),
        .share_a_i  (share_a_i),
        .share_b_i  (share_b_i),
        .ready_i    (ready_i),
        .ready_o    (ready_o),
        .valid_o    (valid_o),
        .instr_id_o (instr_id_o),
        .share_a_o  (share_a_o),
        .share_b_o  (share_b_o)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected)
        begin
            $display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, got, expected);
            $display("*** FAILED ***");
            $fatal(1, "Value mismatch");
        end
    endtask

    // Rows 4 to 10 send two bytes again and again under fresh masks
    // Rows 27 on stall the output
    task automatic build_table();
        logic [7:0] p;
        logic       d;
        for (int r = 0; r < NUM_ROWS; r++)
        begin
            stim_tab[r].mask  = 8'(lfsr_take(8));
            stim_tab[r].tag   = ID_W'(r);
            stim_tab[r].stall = 3'd0;
            if (r < 4)
            begin
                p = KAT_IN[r];
                d = (r >= 2);
            end
            else if (r < 8)
            begin
                p = 8'hA7;
                d = 1'b0;
            end
            else if (r < 11)
            begin
                p = 8'h3C;
                d = 1'b1;
            end
            else
            begin
                p = 8'(lfsr_take(8));
                d = lfsr_take(1) != 0;
                if (r >= 27)
                begin
                    stim_tab[r].stall = 3'(lfsr_take(3));
                end
            end
            stim_tab[r].plain    = p;
            stim_tab[r].dec      = d;
            stim_tab[r].expected = (r < 4) ? KAT_OUT[r] : (d ? inv_sbox_ref(p) : sbox_ref(p));
        end
    endtask

    task automatic drive_rows();
        int waited;
        for (int r = 0; r < NUM_ROWS; r++)
        begin
            valid_i    <= 1'b1;
            share_a_i  <= stim_tab[r].plain ^ stim_tab[r].mask;
            share_b_i  <= stim_tab[r].mask;
            decrypt_i  <= stim_tab[r].dec;
            instr_id_i <= stim_tab[r].tag;
            waited = 0;
            do
            begin
                @(posedge clk_i);
                waited++;
                if (waited > ACCEPT_TIMEOUT)
                begin
                    $display("*** FAILED ***");
                    $fatal(1, "Timed out waiting for the DUT to accept an input byte");
                end
            end
            while (!ready_o);
            exp_q.push_back({stim_tab[r].tag, stim_tab[r].expected});
            acc_time_q.push_back($time);
        end
        valid_i <= 1'b0;
    endtask

    task automatic drain_results();
        logic [ID_W+BYTE_W-1:0] exp;
        logic [BYTE_W-1:0]      held_a;
        logic [BYTE_W-1:0]      held_b;
        logic                   held;
        logic                   done;
        int                     stall_left;
        int                     waited;
        time                    acc_time;
        for (int n = 0; n < NUM_ROWS; n++)
        begin
            stall_left = stim_tab[n].stall;
            ready_i <= (stall_left == 0);
            held = 1'b0;
            done = 1'b0;
            waited = 0;
            while (!done)
            begin
                @(posedge clk_i);
                waited++;
                if (valid_o && ready_i)
                begin
                    check_value("results pending", 32'(exp_q.size() > 0), 32'd1);
                    exp = exp_q.pop_front();
                    acc_time = acc_time_q.pop_front();
                    check_value("output tag", 32'(instr_id_o), 32'(exp[ID_W+BYTE_W-1:BYTE_W]));
                    check_value("unmasked result", 32'(share_a_o ^ share_b_o),
                                32'(exp[BYTE_W-1:0]));
                    if (held)
                    begin
                        check_value("share A after stall", 32'(share_a_o), 32'(held_a));
                        check_value("share B after stall", 32'(share_b_o), 32'(held_b));
                    end
                    if (!stalled_once)
                    begin
                        check_value("latency in cycles",
                                    32'(($time - acc_time) / CLK_PERIOD), PIPE_LATENCY);
                    end
                    done = 1'b1;
                end
                else if (valid_o)
                begin
                    if (held)
                    begin
                        check_value("share A during stall", 32'(share_a_o), 32'(held_a));
                        check_value("share B during stall", 32'(share_b_o), 32'(held_b));
                    end
                    else
                    begin
                        held_a = share_a_o;
                        held_b = share_b_o;
                        held = 1'b1;
                        stalled_once = 1'b1;
                    end
                    stall_left--;
                    if (stall_left <= 0)
                    begin
                        ready_i <= 1'b1;
                    end
                end
                else if (held)
                begin
                    check_value("valid_o during stall", 32'(valid_o), 32'd1);
                end
                if (!done && waited > RESULT_TIMEOUT)
                begin
                    $display("*** FAILED ***");
                    $fatal(1, "Timed out waiting for a result from the DUT");
                end
            end
        end
    endtask

    initial
    begin
        rst_n        = 1'b0;
        valid_i      = 1'b0;
        instr_id_i   = '0;
        decrypt_i    = 1'b0;
        share_a_i    = '0;
        share_b_i    = '0;
        // Low so that ready_o reflects the empty stages
        ready_i      = 1'b0;
        stalled_once = 1'b0;
        build_table();

        @(posedge clk_i);
        @(posedge clk_i);
        check_value("valid_o in reset", 32'(valid_o), 32'd0);
        check_value("ready_o in reset", 32'(ready_o), 32'd1);
        rst_n <= 1'b1;
        @(posedge clk_i);
        check_value("valid_o after reset", 32'(valid_o), 32'd0);
        check_value("ready_o after reset", 32'(ready_o), 32'd1);

        fork
            drive_rows();
            drain_results();
        join

        // Nothing may come out once every byte is accounted for
        repeat (3)
        begin
            @(posedge clk_i);
            check_value("valid_o after the last result", 32'(valid_o), 32'd0);
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+test
src/sbox_pkg.sv
src/sbox_pipe_ctrl.sv
src/sbox_input_map.sv
src/gf256_inv_front.sv
src/gf16_inv_dom.sv
src/gf256_inv_back.sv
src/masked_sbox_top.sv
test/tb_masked_sbox.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module tb_masked_sbox \
    -f verilog.f -Mdir obj_dir &&
./obj_dir/Vtb_masked_sbox ||
{ echo "Simulation did not complete successfully"; exit 1; }
